// File: Bender.yml
package:
  name: tlb

export_include_dirs:
  - .

sources:
  - files:
      - tlb_pkg.sv
      - tlbCamLine.sv
      - tlbCam.sv
      - tlbPageRam.sv
      - tlbTranslate.sv
      - tlb.sv
  - target: simulation
    files:
      - tb_tlb.sv

// File: all.f
+incdir+.
tlb_pkg.sv
tlbCamLine.sv
tlbCam.sv
tlbPageRam.sv
tlbTranslate.sv
tlb.sv
tb_tlb.sv

// File: tb_tlb.sv
////////////////////
// Testbench for the Sv39 TLB
// Runs fills, lookups and flushes against an array reference model,
// with concurrent assertions checking every registered result
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tb_tlb import tlb_pkg::*; ();

  localparam int TimeoutCycles = 20;

  logic     clk;
  logic     rstN;
  logic     lookupReq;
  vpnT      lookupVpn;
  logic     fillReq;
  vpnT      fillVpn;
  pageTypeT fillPageType;
  ppnT      fillPpn;
  logic     flush;
  logic     resultValid;
  logic     hit;
  ppnT      physPageNum;

  // Reference copy of the buffer contents and its round-robin pointer
  vpnT      mdlKey [`TLB_ENTRIES];
  pageTypeT mdlType [`TLB_ENTRIES];
  ppnT      mdlPpn [`TLB_ENTRIES];
  logic     mdlValid [`TLB_ENTRIES];
  int       mdlVictim;

  // Expectation staged one cycle so it lines up with resultValid
  logic expHitD;
  logic expHitQ;
  ppnT  expPpnD;
  ppnT  expPpnQ;
  logic lookupReqQ;
  int   lookupCount;
  int   resultCount;

  // Top segments already handed out, so no two generated keys overlap
  logic seg2Used [1 << `TLB_SEG_BITS];
  int   seed;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  tlb u_dut (
    .clk          (clk),
    .rstN         (rstN),
    .lookupReq    (lookupReq),
    .lookupVpn    (lookupVpn),
    .fillReq      (fillReq),
    .fillVpn      (fillVpn),
    .fillPageType (fillPageType),
    .fillPpn      (fillPpn),
    .flush        (flush),
    .resultValid  (resultValid),
    .hit          (hit),
    .physPageNum  (physPageNum)
  );

  always @(posedge clk) begin
    expHitQ    <= expHitD;
    expPpnQ    <= expPpnD;
    lookupReqQ <= lookupReq;
    if (resultValid) begin
      resultCount <= resultCount + 1;
    end
  end

  task automatic reportMismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic reportFailure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  ////////////////////
  // Checks
  ////////////////////

  hitCheck: assert property (@(posedge clk) disable iff (!rstN)
                             resultValid |-> (hit == expHitQ))
    else reportMismatch("hit", $sampled(expHitQ), $sampled(hit));

  ppnCheck: assert property (@(posedge clk) disable iff (!rstN)
                             resultValid |-> (physPageNum == expPpnQ))
    else reportMismatch("physPageNum", $sampled(expPpnQ), $sampled(physPageNum));

  // Exactly one result per request, one cycle later
  validCheck: assert property (@(posedge clk) disable iff (!rstN)
                               resultValid == lookupReqQ)
    else reportMismatch("resultValid", $sampled(lookupReqQ), $sampled(resultValid));

  idleHitCheck: assert property (@(posedge clk) disable iff (!rstN) !resultValid |-> !hit)
    else reportMismatch("hit", 64'd0, $sampled(hit));

  ////////////////////
  // Model and stimulus helpers
  ////////////////////

  // Care mask per page size, the don't-care bits pass straight to the PPN
  function automatic void modelLookup(input vpnT vpn, output logic mHit, output ppnT mPpn);
    vpnT care;
    vpnT passThru;
    mHit = 1'b0;
    mPpn = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      case (mdlType[i])
        kiloPage: care = '1;
        megaPage: care = {{(2 * `TLB_SEG_BITS){1'b1}}, {`TLB_SEG_BITS{1'b0}}};
        default:  care = {{`TLB_SEG_BITS{1'b1}}, {(2 * `TLB_SEG_BITS){1'b0}}};
      endcase
      passThru = ~care;
      if (!mHit && mdlValid[i] && (((vpn ^ mdlKey[i]) & care) == '0)) begin
        mHit = 1'b1;
        mPpn = (mdlPpn[i] & ~ppnT'(passThru)) | ppnT'(vpn & passThru);
      end
    end
  endfunction

  task automatic newKey(output vpnT key);
    logic [`TLB_SEG_BITS-1:0] top;
    top = $random(seed);
    while (seg2Used[top]) begin
      top = top + 1'b1;
    end
    seg2Used[top] = 1'b1;
    key = {top, (2 * `TLB_SEG_BITS)'($random(seed))};
  endtask

  task automatic randomPpn(output ppnT ppn);
    logic [31:0] hiWord;
    logic [31:0] loWord;
    hiWord = $random(seed);
    loWord = $random(seed);
    ppn = ppnT'({hiWord, loWord});
  endtask

  // Every cycle starts with all strobes low, the issue tasks raise them
  task automatic startCycle();
    @(posedge clk);
    lookupReq <= 1'b0;
    fillReq   <= 1'b0;
    flush     <= 1'b0;
  endtask

  // Call before issueFill in the same cycle, the lookup sees old contents
  task automatic issueLookup(input vpnT vpn);
    logic mHit;
    ppnT  mPpn;
    modelLookup(vpn, mHit, mPpn);
    lookupReq <= 1'b1;
    lookupVpn <= vpn;
    expHitD   <= mHit;
    expPpnD   <= mPpn;
    lookupCount++;
  endtask

  task automatic issueFill(input vpnT key, input pageTypeT kind, input ppnT ppn);
    fillReq      <= 1'b1;
    fillVpn      <= key;
    fillPageType <= kind;
    fillPpn      <= ppn;
    mdlKey[mdlVictim]   = key;
    mdlType[mdlVictim]  = kind;
    mdlPpn[mdlVictim]   = ppn;
    mdlValid[mdlVictim] = 1'b1;
    mdlVictim = (mdlVictim + 1) % `TLB_ENTRIES;
  endtask

  task automatic issueFlush();
    flush <= 1'b1;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      mdlValid[i] = 1'b0;
    end
  endtask

  task automatic waitForResults();
    int cycles;
    cycles = 0;
    startCycle();
    while (resultCount != lookupCount && cycles < TimeoutCycles) begin
      startCycle();
      cycles++;
    end
    if (resultCount != lookupCount) begin
      reportFailure("timed out waiting for resultValid after a lookup request");
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    vpnT key;
    vpnT oldKey;
    vpnT megaKey;
    vpnT gigaKey;
    vpnT probe;
    ppnT ppn;
    seed         = 32'h74689168;
    rstN         = 1'b0;
    lookupReq    = 1'b0;
    lookupVpn    = '0;
    fillReq      = 1'b0;
    fillVpn      = '0;
    fillPageType = kiloPage;
    fillPpn      = '0;
    flush        = 1'b0;
    expHitD      = 1'b0;
    expPpnD      = '0;
    lookupCount  = 0;
    resultCount  = 0;
    mdlVictim    = 0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      mdlValid[i] = 1'b0;
      mdlType[i]  = kiloPage;
      mdlPpn[i]   = '0;
    end
    for (int s = 0; s < (1 << `TLB_SEG_BITS); s++) begin
      seg2Used[s] = 1'b0;
    end
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    // Empty buffer misses with a zero page number
    for (int i = 0; i < 4; i++) begin
      startCycle();
      probe = vpnT'($random(seed));
      issueLookup(probe);
    end
    waitForResults();

    // Eight kilopage fills, then back-to-back lookups of every line
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      newKey(key);
      randomPpn(ppn);
      startCycle();
      issueFill(key, kiloPage, ppn);
    end
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      startCycle();
      issueLookup(mdlKey[i]);
    end
    waitForResults();

    // Ninth fill wraps onto entry 0
    oldKey = mdlKey[0];
    newKey(key);
    randomPpn(ppn);
    startCycle();
    issueFill(key, kiloPage, ppn);
    startCycle();
    issueLookup(oldKey);
    startCycle();
    issueLookup(key);
    waitForResults();

    // Megapage in entry 1 and gigapage in entry 2, probed with random low segments
    newKey(megaKey);
    randomPpn(ppn);
    startCycle();
    issueFill(megaKey, megaPage, ppn);
    newKey(gigaKey);
    randomPpn(ppn);
    startCycle();
    issueFill(gigaKey, gigaPage, ppn);
    for (int i = 0; i < 4; i++) begin
      probe = vpnT'($random(seed));
      startCycle();
      issueLookup({megaKey[`TLB_VPN_BITS-1:`TLB_SEG_BITS], probe[`TLB_SEG_BITS-1:0]});
      startCycle();
      issueLookup({gigaKey[`TLB_VPN_BITS-1:2*`TLB_SEG_BITS], probe[2*`TLB_SEG_BITS-1:0]});
    end
    waitForResults();

    // Flush empties the buffer, even for a fill in the same cycle
    startCycle();
    issueFlush();
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      startCycle();
      issueLookup(mdlKey[i]);
    end
    newKey(key);
    randomPpn(ppn);
    startCycle();
    issueFill(key, kiloPage, ppn);
    issueFlush();
    startCycle();
    issueLookup(key);

    // A lookup beside its own fill still misses, the next one hits
    newKey(key);
    randomPpn(ppn);
    startCycle();
    issueLookup(key);
    issueFill(key, megaPage, ppn);
    startCycle();
    issueLookup(key);
    waitForResults();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: tlb.sv
////////////////////
// Sv39 TLB top level
// Eight-entry fully associative buffer with round-robin fill,
// global flush and a one-cycle registered lookup
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlb import tlb_pkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     lookupReq,
  input  vpnT      lookupVpn,
  input  logic     fillReq,
  input  vpnT      fillVpn,
  input  pageTypeT fillPageType,
  input  ppnT      fillPpn,
  input  logic     flush,
  output logic     resultValid,
  output logic     hit,
  output ppnT      physPageNum
);

  // CAM results toward the translate stage
  lineVecT                      lineMatch;
  pageTypeT [`TLB_ENTRIES-1:0] linePageType;

  // Victim select shared by the CAM lines and the page RAM
  lineVecT                      fillLines;

  // Stored page numbers of every entry
  ppnT [`TLB_ENTRIES-1:0]      linePpn;

  tlbCam uCam (
    .clk          (clk),
    .rstN         (rstN),
    .lookupVpn    (lookupVpn),
    .fillReq      (fillReq),
    .fillVpn      (fillVpn),
    .fillPageType (fillPageType),
    .flush        (flush),
    .lineMatch    (lineMatch),
    .linePageType (linePageType),
    .fillLines    (fillLines)
  );

  tlbPageRam uPageRam (
    .clk       (clk),
    .rstN      (rstN),
    .fillLines (fillLines),
    .fillPpn   (fillPpn),
    .linePpn   (linePpn)
  );

  tlbTranslate uTranslate (
    .clk          (clk),
    .rstN         (rstN),
    .lookupReq    (lookupReq),
    .lookupVpn    (lookupVpn),
    .lineMatch    (lineMatch),
    .linePageType (linePageType),
    .linePpn      (linePpn),
    .resultValid  (resultValid),
    .hit          (hit),
    .physPageNum  (physPageNum)
  );

endmodule

`default_nettype wire

// File: tlbCam.sv
////////////////////
// TLB CAM array
// Eight associative lines plus the round-robin victim pointer
// that picks which line a fill overwrites
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlbCam import tlb_pkg::*; (
  input  logic                         clk,
  input  logic                         rstN,
  input  vpnT                          lookupVpn,
  input  logic                         fillReq,
  input  vpnT                          fillVpn,
  input  pageTypeT                     fillPageType,
  input  logic                         flush,
  output lineVecT                      lineMatch,
  output pageTypeT [`TLB_ENTRIES-1:0] linePageType,
  output lineVecT                      fillLines
);

  localparam int PtrBits = $clog2(`TLB_ENTRIES);

  logic [PtrBits-1:0] victimPtr;

  ////////////////////
  // Victim selection
  ////////////////////

  // The pointer steps once per fill and wraps on its own since the
  // entry count is a power of two
  // A flush leaves it where it is
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      victimPtr <= '0;
    end else if (fillReq) begin
      victimPtr <= victimPtr + 1'b1;
    end
  end

  // One-hot write select, shared with the page RAM so both halves
  // of the entry land in the same slot
  assign fillLines = fillReq ? (lineVecT'(1) << victimPtr) : '0;

  ////////////////////
  // Lines
  ////////////////////

  for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : genLine
    tlbCamLine uLine (
      .clk           (clk),
      .rstN          (rstN),
      .lookupVpn     (lookupVpn),
      .lineWrite     (fillLines[i]),
      .writeVpn      (fillVpn),
      .writePageType (fillPageType),
      .flush         (flush),
      .pageType      (linePageType[i]),
      .match         (lineMatch[i])
    );
  end

endmodule

`default_nettype wire

// File: tlbCamLine.sv
////////////////////
// TLB CAM line
// Holds one key, its page type and a valid bit, and reports a match
// with the lower segments masked according to the page size
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlbCamLine import tlb_pkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  vpnT      lookupVpn,
  input  logic     lineWrite,
  input  vpnT      writeVpn,
  input  pageTypeT writePageType,
  input  logic     flush,
  output pageTypeT pageType,
  output logic     match
);

  logic valid;
  vpnT  key;

  // Stored key and query split into their three segments
  logic [`TLB_SEG_BITS-1:0] keySeg0, keySeg1, keySeg2;
  logic [`TLB_SEG_BITS-1:0] qrySeg0, qrySeg1, qrySeg2;

  assign {keySeg2, keySeg1, keySeg0} = key;
  assign {qrySeg2, qrySeg1, qrySeg0} = lookupVpn;

  ////////////////////
  // Masked compare
  ////////////////////

  // The top segment always takes part in the compare
  // Segment 1 is a don't-care for gigapages, segment 0 for anything above a kilopage
  assign match = valid
               && (qrySeg2 == keySeg2)
               && ((qrySeg1 == keySeg1) || (pageType != kiloPage && pageType != megaPage))
               && ((qrySeg0 == keySeg0) || (pageType != kiloPage));

  ////////////////////
  // Entry state
  ////////////////////

  // Flush beats a write on the valid bit, but the write still lands its type
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid    <= 1'b0;
      pageType <= kiloPage;
    end else begin
      if (flush) begin
        valid <= 1'b0;
      end else if (lineWrite) begin
        valid <= 1'b1;
      end
      if (lineWrite) begin
        pageType <= writePageType;
      end
    end
  end

  // Key is only meaningful while valid is set
  always_ff @(posedge clk) begin
    if (lineWrite) begin
      key <= writeVpn;
    end
  end

endmodule

`default_nettype wire

// File: tlbPageRam.sv
////////////////////
// TLB page number storage
// One physical page number register per entry, written by the
// same one-hot select that writes the CAM line
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlbPageRam import tlb_pkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  lineVecT                 fillLines,
  input  ppnT                     fillPpn,
  output ppnT [`TLB_ENTRIES-1:0] linePpn
);

  // All entries are visible at once so the translate stage can
  // select by match without an address decode
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      linePpn <= '0;
    end else begin
      // At most one bit of fillLines is set
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
        if (fillLines[i]) begin
          linePpn[i] <= fillPpn;
        end
      end
    end
  end

  // The valid state lives in the CAM
  // A flushed entry keeps its stale number here, masked by its missing match

endmodule

`default_nettype wire

// File: tlbTranslate.sv
////////////////////
// TLB translate stage
// Picks the matching entry, merges superpage offsets from the lookup
// VPN and registers hit and physical page number
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "tlb_consts.svh"

module tlbTranslate import tlb_pkg::*; (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         lookupReq,
  input  vpnT                          lookupVpn,
  input  lineVecT                      lineMatch,
  input  pageTypeT [`TLB_ENTRIES-1:0] linePageType,
  input  ppnT [`TLB_ENTRIES-1:0]      linePpn,
  output logic                         resultValid,
  output logic                         hit,
  output ppnT                          physPageNum
);

  logic     selHit;
  pageTypeT selType;
  ppnT      selPpn;
  ppnT      mergedPpn;

  ////////////////////
  // Select and merge
  ////////////////////

  // Scan from the top so the lowest matching index is the one that sticks
  // With no match the number stays zero, which is the miss value
  always_comb begin
    selHit  = 1'b0;
    selType = kiloPage;
    selPpn  = '0;
    for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
      if (lineMatch[i]) begin
        selHit  = 1'b1;
        selType = linePageType[i];
        selPpn  = linePpn[i];
      end
    end
  end

  // Superpages take their low segments straight from the virtual address
  always_comb begin
    mergedPpn = selPpn;
    if (selType != kiloPage) begin
      mergedPpn[`TLB_SEG_BITS-1:0] = lookupVpn[`TLB_SEG_BITS-1:0];
    end
    if (selType != kiloPage && selType != megaPage) begin
      mergedPpn[2*`TLB_SEG_BITS-1:`TLB_SEG_BITS] = lookupVpn[2*`TLB_SEG_BITS-1:`TLB_SEG_BITS];
    end
  end

  ////////////////////
  // Result register
  ////////////////////

  // Hit is qualified by the request so it never shows without resultValid
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      hit         <= 1'b0;
    end else begin
      resultValid <= lookupReq;
      hit         <= lookupReq && selHit;
    end
  end

  // The number only moves on a request and holds in between
  always_ff @(posedge clk) begin
    if (lookupReq) begin
      physPageNum <= mergedPpn;
    end
  end

endmodule

`default_nettype wire

// File: tlb_consts.svh
////////////////////
// Sv39 TLB sizing constants
// Entry count and the virtual and physical page number widths
////////////////////

`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// Number of fully associative entries in the buffer
`define TLB_ENTRIES 8

// Width of one VPN segment, one per page table level
`define TLB_SEG_BITS 9

// Sv39 walks three levels
`define TLB_LEVELS 3

// The lookup key covers all three segments, 27 bits
`define TLB_VPN_BITS (`TLB_LEVELS * `TLB_SEG_BITS)

// Sv39 physical page number width
`define TLB_PPN_BITS 44

`endif

// File: tlb_pkg.sv
////////////////////
// Sv39 TLB types
// Page type encoding and the vectors shared by the TLB blocks
////////////////////

`default_nettype none

`include "tlb_consts.svh"

package tlb_pkg;

  // Page size of an entry
  // The unused fourth code behaves like a gigapage everywhere
  typedef enum logic [1:0] {
    kiloPage = 2'd0,
    megaPage = 2'd1,
    gigaPage = 2'd2
  } pageTypeT;

  typedef logic [`TLB_VPN_BITS-1:0] vpnT;
  typedef logic [`TLB_PPN_BITS-1:0] ppnT;

  // One bit per entry, used one-hot for the fill select
  typedef logic [`TLB_ENTRIES-1:0] lineVecT;

endpackage

`default_nettype wire
